// File: design/exec_cfg_pkg.sv
// Machine configuration of the execution back end.
// Holds the datapath widths, lane and register counts, pipeline depths
// and the result record each lane hands to writeback.

package exec_cfg_pkg;

    // Datapath word width
    localparam int DATA_WIDTH = 32;

    // One execution lane per core
    localparam int LANES = 4;
    localparam int CORE_WIDTH = 2;

    // Per-core register bank
    localparam int REG_COUNT = 16;
    localparam int REG_ADDR_WIDTH = 4;

    // Cycles from lane input to the formatted lane output
    localparam int ALU_DEPTH = 3;

    // Issue register, lane pipeline and writeback register together
    localparam int TOTAL_LATENCY = 1 + ALU_DEPTH + 1;

    // Formatted result leaving one lane
    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [DATA_WIDTH-1:0]     data;
    } lane_result_t;

endpackage

// File: design/exec_isa_pkg.sv
// Instruction set of the execution back end.
// Defines the opcode encoding, the instruction word presented to issue
// and the tag that travels beside the ALU through a lane.

package exec_isa_pkg;

    typedef enum logic [3:0] {
        NOP    = 4'd0,
        ADD    = 4'd1,
        SUB    = 4'd2,
        MUL    = 4'd3,
        LAND   = 4'd4,
        LOR    = 4'd5,
        LNOT   = 4'd6,
        SATP   = 4'd7,
        SATN   = 4'd8,
        ABS    = 4'd9,
        POPCNT = 4'd10,
        BGT    = 4'd11,
        BLE    = 4'd12,
        BEQ    = 4'd13,
        BNE    = 4'd14,
        LDC    = 4'd15
    } opcode_t;

    // Operands arrive as values, the core field picks the lane
    typedef struct packed {
        opcode_t                                 opcode;
        logic [exec_cfg_pkg::DATA_WIDTH-1:0]     operand_a;
        logic [exec_cfg_pkg::DATA_WIDTH-1:0]     operand_b;
        logic [exec_cfg_pkg::REG_ADDR_WIDTH-1:0] dest;
        logic [exec_cfg_pkg::CORE_WIDTH-1:0]     core;
    } exec_instr_t;

    // Carried in step with the ALU so the output stage knows how to format
    typedef struct packed {
        opcode_t                                 opcode;
        logic [exec_cfg_pkg::REG_ADDR_WIDTH-1:0] dest;
    } exec_tag_t;

endpackage

// File: design/pipe_delay.sv
// Fixed-depth delay line for an arbitrary payload type.
// Each stage carries a valid bit; only the valid bits are cleared by reset,
// the payload simply shifts along with them.

`timescale 1ns/1ps

module pipe_delay #(
    parameter type T = logic [31:0],
    parameter int DEPTH = 1
) (
    input  logic clock,
    input  logic rst,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    logic [DEPTH-1:0] valid_sr;
    T                 data_sr [DEPTH];

    always_ff @(posedge clock) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        data_sr[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

    assign out_valid = valid_sr[DEPTH-1];
    assign out_data  = data_sr[DEPTH-1];

endmodule

// File: design/exec_alu.sv
// Pipelined integer ALU of one execution lane.
// The raw result is computed combinationally, registered once and then
// delayed so that it appears ALU_DEPTH cycles after the operands.
// Compares leave a 1 or 0 in the low byte for the lane to expand.

`timescale 1ns/1ps

module exec_alu (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                in_valid,
    input  exec_isa_pkg::opcode_t               opcode,
    input  logic [exec_cfg_pkg::DATA_WIDTH-1:0] operand_a,
    input  logic [exec_cfg_pkg::DATA_WIDTH-1:0] operand_b,
    output logic                                out_valid,
    output logic [exec_cfg_pkg::DATA_WIDTH-1:0] out_data
);

    import exec_isa_pkg::*;
    import exec_cfg_pkg::*;

    logic [DATA_WIDTH-1:0] raw_data;
    logic [DATA_WIDTH-1:0] product;
    logic                  a_gt_b;
    logic                  a_eq_b;

    logic                  stage_valid;
    logic [DATA_WIDTH-1:0] stage_data;

    // Only the low word of the product is kept
    assign product = operand_a * operand_b;

    assign a_gt_b = $signed(operand_a) > $signed(operand_b);
    assign a_eq_b = operand_a == operand_b;

    always_comb begin
        case (opcode)
            ADD:     raw_data = operand_a + operand_b;
            SUB:     raw_data = operand_a - operand_b;
            MUL:     raw_data = product;
            LAND:    raw_data = operand_a & operand_b;
            LOR:     raw_data = operand_a | operand_b;
            LNOT:    raw_data = ~operand_a;
            // Signed minimum clamps a from above by b
            SATP:    raw_data = a_gt_b ? operand_b : operand_a;
            // Signed maximum clamps a from below by b
            SATN:    raw_data = a_gt_b ? operand_a : operand_b;
            // The most negative value negates onto itself and is left as it is
            ABS:     raw_data = operand_a[DATA_WIDTH-1] ? -operand_a : operand_a;
            POPCNT:  raw_data = DATA_WIDTH'($countones(operand_a));
            BGT:     raw_data = DATA_WIDTH'(a_gt_b);
            BLE:     raw_data = DATA_WIDTH'(!a_gt_b);
            BEQ:     raw_data = DATA_WIDTH'(a_eq_b);
            BNE:     raw_data = DATA_WIDTH'(!a_eq_b);
            LDC:     raw_data = operand_a;
            default: raw_data = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        stage_data <= raw_data;
    end

    // Remaining stages just align the result with the lane tag
    pipe_delay #(
        .T     (logic [DATA_WIDTH-1:0]),
        .DEPTH (ALU_DEPTH - 1)
    ) result_delay (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (stage_valid),
        .in_data   (stage_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: design/exec_lane.sv
// Execution lane of one core.
// Runs the ALU and a matching tag delay line, then formats the result
// from the delayed opcode before it goes to writeback.

`timescale 1ns/1ps

module exec_lane (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        in_valid,
    input  exec_isa_pkg::exec_instr_t   in_instr,
    output exec_cfg_pkg::lane_result_t  result
);

    import exec_isa_pkg::*;
    import exec_cfg_pkg::*;

    logic                  alu_valid;
    logic [DATA_WIDTH-1:0] alu_data;

    exec_tag_t             tag_in;
    exec_tag_t             tag_out;
    logic                  tag_valid;

    exec_alu alu (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .opcode    (in_instr.opcode),
        .operand_a (in_instr.operand_a),
        .operand_b (in_instr.operand_b),
        .out_valid (alu_valid),
        .out_data  (alu_data)
    );

    assign tag_in = '{opcode: in_instr.opcode, dest: in_instr.dest};

    pipe_delay #(
        .T     (exec_tag_t),
        .DEPTH (ALU_DEPTH)
    ) tag_delay (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (tag_in),
        .out_valid (tag_valid),
        .out_data  (tag_out)
    );

    always_comb begin
        case (tag_out.opcode)
            BGT, BLE, BEQ, BNE: begin
                result.valid = alu_valid;
                result.dest  = tag_out.dest;
                result.data  = (alu_data[7:0] != 8'd0) ? '1 : '0;
            end
            NOP: begin
                result = '0;
            end
            default: begin
                result.valid = alu_valid;
                result.dest  = tag_out.dest;
                result.data  = alu_data;
            end
        endcase
    end

    // The two delay paths must stay in lock step or the tag misdescribes the data
    assert property (@(posedge clock) disable iff (rst) alu_valid == tag_valid);

endmodule

// File: design/issue_dispatch.sv
// Issue stage of the execution back end.
// Registers one instruction per cycle and raises the valid of the lane
// named by its core field; all lanes share the registered instruction bus.

`timescale 1ns/1ps

module issue_dispatch (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             in_valid,
    input  exec_isa_pkg::exec_instr_t        in_instr,
    output logic [exec_cfg_pkg::LANES-1:0]   lane_valid,
    output exec_isa_pkg::exec_instr_t        lane_instr
);

    import exec_cfg_pkg::*;

    logic [LANES-1:0] core_onehot;

    assign core_onehot = LANES'(1) << in_instr.core;

    always_ff @(posedge clock) begin
        if (rst) begin
            lane_valid <= '0;
        end else if (in_valid) begin
            lane_valid <= core_onehot;
        end else begin
            lane_valid <= '0;
        end
    end

    always_ff @(posedge clock) begin
        lane_instr <= in_instr;
    end

    // Each instruction reaches at most one lane
    assert property (@(posedge clock) disable iff (rst) $onehot0(lane_valid));

endmodule

// File: design/result_writeback.sv
// Writeback stage of the execution back end.
// Picks the one valid lane result, writes it into that core's register
// bank and registers the result strobe with its core index.
// The read port is combinational and returns what the last edge wrote.

`timescale 1ns/1ps

module result_writeback (
    input  logic                                              clock,
    input  logic                                              rst,
    input  exec_cfg_pkg::lane_result_t [exec_cfg_pkg::LANES-1:0] lane_results,
    output logic                                              result_valid,
    output logic [exec_cfg_pkg::CORE_WIDTH-1:0]               result_core,
    output logic [exec_cfg_pkg::REG_ADDR_WIDTH-1:0]           result_dest,
    output logic [exec_cfg_pkg::DATA_WIDTH-1:0]               result_data,
    input  logic [exec_cfg_pkg::CORE_WIDTH-1:0]               rd_core,
    input  logic [exec_cfg_pkg::REG_ADDR_WIDTH-1:0]           rd_addr,
    output logic [exec_cfg_pkg::DATA_WIDTH-1:0]               rd_data
);

    import exec_cfg_pkg::*;

    logic [DATA_WIDTH-1:0] reg_bank [LANES][REG_COUNT];

    logic [LANES-1:0]      valid_vec;
    logic                  sel_valid;
    logic [CORE_WIDTH-1:0] sel_core;
    lane_result_t          sel_result;

    // Lanes have equal latency, so at most one is valid and no priority is needed
    always_comb begin
        sel_valid  = 1'b0;
        sel_core   = '0;
        sel_result = '0;
        for (int i = 0; i < LANES; i++) begin
            valid_vec[i] = lane_results[i].valid;
            if (lane_results[i].valid) begin
                sel_valid  = 1'b1;
                sel_core   = CORE_WIDTH'(i);
                sel_result = lane_results[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            result_valid <= 1'b0;
            for (int c = 0; c < LANES; c++) begin
                for (int r = 0; r < REG_COUNT; r++) begin
                    reg_bank[c][r] <= '0;
                end
            end
        end else begin
            result_valid <= sel_valid;
            if (sel_valid) begin
                reg_bank[sel_core][sel_result.dest] <= sel_result.data;
            end
        end
    end

    always_ff @(posedge clock) begin
        result_core <= sel_core;
        result_dest <= sel_result.dest;
        result_data <= sel_result.data;
    end

    assign rd_data = reg_bank[rd_core][rd_addr];

    assert property (@(posedge clock) disable iff (rst) $onehot0(valid_vec));

endmodule

// File: design/exec_top.sv
// Top level of the multi-core execution back end.
// Instructions flow from issue through the lane of their core into the
// shared writeback; results appear TOTAL_LATENCY cycles after issue.

`timescale 1ns/1ps

module exec_top (
    input  logic                                    clock,
    input  logic                                    rst,
    input  logic                                    in_valid,
    input  exec_isa_pkg::exec_instr_t               in_instr,
    output logic                                    result_valid,
    output logic [exec_cfg_pkg::CORE_WIDTH-1:0]     result_core,
    output logic [exec_cfg_pkg::REG_ADDR_WIDTH-1:0] result_dest,
    output logic [exec_cfg_pkg::DATA_WIDTH-1:0]     result_data,
    input  logic [exec_cfg_pkg::CORE_WIDTH-1:0]     rd_core,
    input  logic [exec_cfg_pkg::REG_ADDR_WIDTH-1:0] rd_addr,
    output logic [exec_cfg_pkg::DATA_WIDTH-1:0]     rd_data
);

    import exec_isa_pkg::*;
    import exec_cfg_pkg::*;

    logic [LANES-1:0]                lane_valid;
    exec_instr_t                     lane_instr;
    lane_result_t [LANES-1:0]        lane_results;

    issue_dispatch dispatch (
        .clock      (clock),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .lane_valid (lane_valid),
        .lane_instr (lane_instr)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        exec_lane lane (
            .clock    (clock),
            .rst      (rst),
            .in_valid (lane_valid[i]),
            .in_instr (lane_instr),
            .result   (lane_results[i])
        );
    end

    result_writeback writeback (
        .clock        (clock),
        .rst          (rst),
        .lane_results (lane_results),
        .result_valid (result_valid),
        .result_core  (result_core),
        .result_dest  (result_dest),
        .result_data  (result_data),
        .rd_core      (rd_core),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

// File: testbench/tb_exec_top.sv
// Random-stimulus testbench for the execution back end.
// Drives instruction streams into exec_top, predicts every result from the
// opcode rules and checks the result strobe, its timing and the register banks.

`timescale 1ns/1ps

module tb_exec_top;

    import exec_isa_pkg::*;
    import exec_cfg_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int N_PER_TEST   = 120;
    localparam int N_MIX        = 300;
    localparam int N_READ       = LANES * REG_COUNT;
    localparam int DRAIN_LIMIT  = TOTAL_LATENCY + 2;
    localparam int TEST_CYCLES  = RESET_CYCLES + 5 * N_PER_TEST + N_MIX + 3 * N_READ
                                  + 6 * DRAIN_LIMIT;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TOTAL_LATENCY + 50;

    // One predicted result and the cycle on which it must show up
    typedef struct packed {
        logic [31:0]               due;
        logic [CORE_WIDTH-1:0]     core;
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [DATA_WIDTH-1:0]     data;
    } expect_t;

    logic                      clock = 1'b0;
    logic                      rst;
    logic                      in_valid;
    exec_instr_t               in_instr;
    logic                      result_valid;
    logic [CORE_WIDTH-1:0]     result_core;
    logic [REG_ADDR_WIDTH-1:0] result_dest;
    logic [DATA_WIDTH-1:0]     result_data;
    logic [CORE_WIDTH-1:0]     rd_core;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [DATA_WIDTH-1:0]     rd_data;

    int                    seed = 32'h8e80_ac7d;
    int                    errors = 0;
    int                    checks = 0;
    logic [31:0]           cycle = 0;
    expect_t               exp_q [$];
    logic [DATA_WIDTH-1:0] shadow [LANES][REG_COUNT];

    exec_top DUT (
        .clock        (clock),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .result_valid (result_valid),
        .result_core  (result_core),
        .result_dest  (result_dest),
        .result_data  (result_data),
        .rd_core      (rd_core),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Counts rising edges, read only on falling edges
    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // Expected result from the instruction set rules, bit 32 set when a register is written
    function automatic logic [32:0] model_result(input opcode_t op, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        d;
        logic               w;
        int                 ones;
        sa = a;
        sb = b;
        d = '0;
        w = 1'b1;
        ones = 0;
        case (op)
            NOP:    w = 1'b0;
            ADD:    d = a + b;
            SUB:    d = a - b;
            MUL:    d = a * b;
            LAND:   d = a & b;
            LOR:    d = a | b;
            LNOT:   d = ~a;
            SATP:   d = (sa < sb) ? a : b;
            SATN:   d = (sa < sb) ? b : a;
            ABS:    d = (sa < 0) ? 32'd0 - a : a;
            POPCNT: begin
                for (int i = 0; i < 32; i++) begin
                    ones += a[i];
                end
                d = ones;
            end
            BGT:    d = (sa > sb) ? '1 : '0;
            BLE:    d = (sa <= sb) ? '1 : '0;
            BEQ:    d = (a == b) ? '1 : '0;
            BNE:    d = (a != b) ? '1 : '0;
            LDC:    d = a;
            default: w = 1'b0;
        endcase
        return {w, d};
    endfunction

    // Boundary values and near neighbours of a base word show up often
    function automatic logic [31:0] biased_word(input logic [31:0] base);
        case ($random(seed) & 7)
            0: return 32'h8000_0000;
            1: return 32'h7fff_ffff;
            2: return 32'h0000_0000;
            3: return 32'hffff_ffff;
            4: return base;
            5: return base + 1;
            6: return base - 1;
            default: return $random(seed);
        endcase
    endfunction

    function automatic exec_instr_t make_instr(input int test_id, input int idx);
        exec_instr_t instr;
        int          r;
        r = $random(seed) & 32'h7fff_ffff;
        instr.operand_a = $random(seed);
        instr.operand_b = $random(seed);
        instr.dest = $random(seed);
        instr.core = $random(seed);
        case (test_id)
            1: begin
                case (r % 4)
                    0: instr.opcode = ADD;
                    1: instr.opcode = SUB;
                    2: instr.opcode = MUL;
                    default: instr.opcode = LDC;
                endcase
            end
            2: begin
                case (r % 5)
                    0: instr.opcode = LAND;
                    1: instr.opcode = LOR;
                    2: instr.opcode = LNOT;
                    3: instr.opcode = ABS;
                    default: instr.opcode = POPCNT;
                endcase
                if (idx % 4 == 0) begin
                    instr.operand_a = 32'h8000_0000;
                end
            end
            3: begin
                instr.opcode = (r % 2 == 0) ? SATP : SATN;
                instr.operand_a = biased_word(instr.operand_a);
                instr.operand_b = biased_word(instr.operand_a);
            end
            4: begin
                instr.opcode = opcode_t'(int'(BGT) + r % 4);
                instr.operand_b = biased_word(instr.operand_a);
            end
            5: instr.opcode = (idx % 2 == 0) ? NOP : opcode_t'(1 + r % 15);
            default: instr.opcode = opcode_t'(r % 16);
        endcase
        return instr;
    endfunction

    // Compares the writeback outputs with the head of the prediction queue
    task automatic check_outputs();
        expect_t e;
        if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
            e = exp_q.pop_front();
            if (!result_valid) begin
                $display("Result strobe missing at cycle %0d", cycle);
                errors++;
            end else begin
                check_value("result_core", result_core, e.core);
                check_value("result_dest", result_dest, e.dest);
                check_value("result_data", result_data, e.data);
            end
        end else if (result_valid) begin
            $display("Unexpected result strobe at cycle %0d", cycle);
            errors++;
        end
    endtask

    task automatic issue_instr(input logic valid, input exec_instr_t instr);
        expect_t     e;
        logic [32:0] res;
        @(negedge clock);
        check_outputs();
        in_valid = valid;
        in_instr = instr;
        res = model_result(instr.opcode, instr.operand_a, instr.operand_b);
        if (valid && res[32]) begin
            e.due  = cycle + TOTAL_LATENCY;
            e.core = instr.core;
            e.dest = instr.dest;
            e.data = res[31:0];
            exp_q.push_back(e);
            shadow[instr.core][instr.dest] = res[31:0];
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            issue_instr(1'b0, '0);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d results still outstanding after the pipeline drained", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic readback_all();
        for (int c = 0; c < LANES; c++) begin
            for (int r = 0; r < REG_COUNT; r++) begin
                @(negedge clock);
                check_outputs();
                rd_core = c;
                rd_addr = r;
                #1;
                check_value($sformatf("rd_data[%0d][%0d]", c, r), rd_data, shadow[c][r]);
            end
        end
    endtask

    task automatic run_test(input int test_id, input string name, input int count);
        int          start_err;
        logic        valid;
        exec_instr_t instr;
        start_err = errors;
        for (int i = 0; i < count; i++) begin
            instr = make_instr(test_id, i);
            // The mixed stream leaves some cycles idle
            valid = !(test_id == 6 && ($random(seed) & 3) == 0);
            issue_instr(valid, instr);
        end
        drain();
        if (test_id >= 5) begin
            readback_all();
        end
        $display("test %0d %s done: %0d errors", test_id, name, errors - start_err);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        rd_core = '0;
        rd_addr = '0;
        for (int c = 0; c < LANES; c++) begin
            for (int r = 0; r < REG_COUNT; r++) begin
                shadow[c][r] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        readback_all();
        $display("test 0 reset_state done: %0d errors", errors);
        run_test(1, "arithmetic", N_PER_TEST);
        run_test(2, "logic_bits", N_PER_TEST);
        run_test(3, "saturation", N_PER_TEST);
        run_test(4, "compares", N_PER_TEST);
        run_test(5, "nop_interleave", N_PER_TEST);
        run_test(6, "mixed_readback", N_MIX);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
design/exec_cfg_pkg.sv
design/exec_isa_pkg.sv
design/pipe_delay.sv
design/exec_alu.sv
design/exec_lane.sv
design/issue_dispatch.sv
design/result_writeback.sv
design/exec_top.sv
testbench/tb_exec_top.sv

// File: Bender.yml
package:
  name: exec_backend

sources:
  # Packages first, the instruction set depends on the configuration
  - design/exec_cfg_pkg.sv
  - design/exec_isa_pkg.sv
  - design/pipe_delay.sv
  - design/exec_alu.sv
  - design/exec_lane.sv
  - design/issue_dispatch.sv
  - design/result_writeback.sv
  - design/exec_top.sv
  - target: simulation
    files:
      - testbench/tb_exec_top.sv
